// ==== src/cpu8_alu.sv ====
`timescale 1ns/1ps

module cpu8_alu (
  input  logic [cpu8_isa_pkg::alu_op_bits-1:0] alu_op,  // {class, op}
  input  logic [cpu8_mem_pkg::word_bits-1:0]   a_val,
  input  logic [cpu8_mem_pkg::word_bits-1:0]   b_val,
  output logic [cpu8_mem_pkg::word_bits-1:0]   result
);

  logic [cpu8_mem_pkg::word_bits-1:0] flags;
  logic [cpu8_mem_pkg::word_bits-1:0] shl_val;
  logic [cpu8_mem_pkg::word_bits-1:0] shr_val;
  logic                               wide_shift;

  // shifting the whole word out or further gives zero
  assign wide_shift = (b_val >= cpu8_mem_pkg::word_bits);
  assign shl_val    = wide_shift ? '0 : (a_val << b_val);
  assign shr_val    = wide_shift ? '0 : (a_val >> b_val);

  // ------------------
  // compare flag byte
  // ------------------
  always_comb begin
    flags                      = '0;  // top two bits stay clear
    flags[cpu8_isa_pkg::st_eq] = (a_val == b_val);
    flags[cpu8_isa_pkg::st_ne] = (a_val != b_val);
    flags[cpu8_isa_pkg::st_lt] = (a_val <  b_val);  // unsigned
    flags[cpu8_isa_pkg::st_le] = (a_val <= b_val);
    flags[cpu8_isa_pkg::st_gt] = (a_val >  b_val);
    flags[cpu8_isa_pkg::st_ge] = (a_val >= b_val);
  end

  always_comb begin
    result = a_val;
    if (alu_op[cpu8_isa_pkg::alu_op_bits-1]) begin  // two operands
      case (alu_op[2:0])
        cpu8_isa_pkg::op_mov: result = a_val;       // core picks rb as target
        cpu8_isa_pkg::op_add: result = a_val + b_val;
        cpu8_isa_pkg::op_sub: result = a_val - b_val;  // wraps
        cpu8_isa_pkg::op_shl: result = shl_val;
        cpu8_isa_pkg::op_shr: result = shr_val;
        cpu8_isa_pkg::op_cmp: result = flags;
        cpu8_isa_pkg::op_and: result = a_val & b_val;
        default:              result = a_val | b_val;  // op_or
      endcase
    end else begin  // unary on a_val
      case (alu_op[2:0])
        cpu8_isa_pkg::op1_not:  result = ~a_val;
        cpu8_isa_pkg::op1_lnot: result = {{(cpu8_mem_pkg::word_bits-1){1'b0}}, ~|a_val};
        default:                result = a_val;  // not written back
      endcase
    end
  end

endmodule

// ==== src/cpu8_core.sv ====
`timescale 1ns/1ps

module cpu8_core (
  input  logic                                in_clk,
  input  logic                                in_rst,
  // memory handshake
  output logic                                mem_req,
  output logic                                mem_write,
  output logic [cpu8_mem_pkg::addr_bits-1:0]  mem_addr,
  output logic [cpu8_mem_pkg::word_bits-1:0]  mem_wdata,
  input  logic                                mem_ack,
  input  logic [cpu8_mem_pkg::word_bits-1:0]  mem_rdata,
  // debug
  output logic [cpu8_mem_pkg::word_bits-1:0]  instr,
  output logic                                halted
);

  logic [cpu8_isa_pkg::ph_bits-1:0]     phase;
  cpu8_isa_pkg::instr_word_t            instr_q;
  logic [cpu8_mem_pkg::word_bits-1:0]   imm_q;    // word after the opcode

  logic                                 is_r2;
  logic                                 is_r1;
  logic                                 has_imm;
  logic [cpu8_mem_pkg::reg_bits-1:0]    ra_idx;
  logic                                 mem_phase;
  logic                                 issue;    // first cycle of a memory phase
  logic                                 done;     // ack seen

  logic [cpu8_mem_pkg::word_bits-1:0]   pc;
  logic [cpu8_mem_pkg::word_bits-1:0]   rd_data_a;
  logic [cpu8_mem_pkg::word_bits-1:0]   rd_data_b;
  logic [cpu8_isa_pkg::alu_op_bits-1:0] alu_op;
  logic [cpu8_mem_pkg::word_bits-1:0]   alu_result;
  logic                                 wr_en;
  logic [cpu8_mem_pkg::reg_bits-1:0]    wr_idx;
  logic [cpu8_mem_pkg::word_bits-1:0]   wr_data;
  logic                                 pc_inc;

  // ------------------
  // decode helpers
  // ------------------
  assign is_r2   = instr_q.r2.mode;
  assign is_r1   = !is_r2 && (instr_q.r1.cls == cpu8_isa_pkg::cls_r1);
  assign has_imm = !is_r2 && instr_q.r1.imm;  // 0- and 1-register classes only
  assign ra_idx  = is_r2 ? instr_q.r2.ra : instr_q.r1.ra;
  assign alu_op  = is_r2 ? {1'b1, instr_q.r2.op} : {1'b0, instr_q.r1.op};

  assign mem_phase = (phase == cpu8_isa_pkg::ph_fetch)  || (phase == cpu8_isa_pkg::ph_imm) ||
                     (phase == cpu8_isa_pkg::ph_mem_rd) || (phase == cpu8_isa_pkg::ph_mem_wr);
  assign issue = mem_phase && !mem_req;
  assign done  = mem_req && mem_ack;

  // ------------------
  // request and phase
  // ------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      phase     <= cpu8_isa_pkg::ph_fetch;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
      instr_q   <= '0;
    end else begin
      if (issue) begin
        mem_req   <= 1'b1;  // held until ack
        mem_write <= (phase == cpu8_isa_pkg::ph_mem_wr);
      end else if (done) begin
        mem_req   <= 1'b0;  // low in the cycle after the ack
        mem_write <= 1'b0;
      end

      case (phase)
        cpu8_isa_pkg::ph_fetch: begin
          if (done) begin
            instr_q <= mem_rdata;
            phase   <= cpu8_isa_pkg::ph_decode;
          end
        end
        cpu8_isa_pkg::ph_decode: begin
          phase <= has_imm ? cpu8_isa_pkg::ph_imm : cpu8_isa_pkg::ph_exec;
        end
        cpu8_isa_pkg::ph_imm: begin
          if (done) phase <= cpu8_isa_pkg::ph_exec;
        end
        cpu8_isa_pkg::ph_exec: begin
          phase <= cpu8_isa_pkg::ph_fetch;  // register ops finish here
          if (is_r1 && has_imm) begin
            if (instr_q.r1.op == cpu8_isa_pkg::op1_ld) phase <= cpu8_isa_pkg::ph_mem_rd;
            if (instr_q.r1.op == cpu8_isa_pkg::op1_st) phase <= cpu8_isa_pkg::ph_mem_wr;
          end else if (!is_r2 && !is_r1) begin
            case (instr_q)
              cpu8_isa_pkg::op0_halt: phase <= cpu8_isa_pkg::ph_halt;
              default:                phase <= cpu8_isa_pkg::ph_fetch;  // nop, imm skip, undefined
            endcase
          end
        end
        cpu8_isa_pkg::ph_mem_rd,
        cpu8_isa_pkg::ph_mem_wr: begin
          if (done) phase <= cpu8_isa_pkg::ph_fetch;
        end
        cpu8_isa_pkg::ph_halt: begin
          phase <= cpu8_isa_pkg::ph_halt;  // only reset leaves
        end
        default: phase <= cpu8_isa_pkg::ph_fetch;
      endcase
    end
  end

  // address and data latched at issue, steady while req is up
  always_ff @(posedge in_clk) begin
    if (issue) begin
      case (phase)
        cpu8_isa_pkg::ph_fetch,
        cpu8_isa_pkg::ph_imm:    mem_addr <= pc;
        cpu8_isa_pkg::ph_mem_rd: mem_addr <= imm_q;
        default: begin  // ph_mem_wr
          mem_addr  <= imm_q;
          mem_wdata <= rd_data_a;  // register aa
        end
      endcase
    end
    if (done && phase == cpu8_isa_pkg::ph_imm) imm_q <= mem_rdata;
  end

  // ------------------
  // register writeback
  // ------------------
  always_comb begin
    wr_en   = 1'b0;
    wr_idx  = ra_idx;
    wr_data = alu_result;
    pc_inc  = 1'b0;
    case (phase)
      cpu8_isa_pkg::ph_fetch,
      cpu8_isa_pkg::ph_imm: pc_inc = done;  // step past the word just read
      cpu8_isa_pkg::ph_exec: begin
        if (is_r2) begin
          wr_en = 1'b1;
          if (instr_q.r2.op == cpu8_isa_pkg::op_mov) wr_idx = instr_q.r2.rb;
          if (instr_q.r2.op == cpu8_isa_pkg::op_cmp) wr_idx = cpu8_isa_pkg::status_idx;
        end else if (is_r1 && has_imm) begin
          if (instr_q.r1.op == cpu8_isa_pkg::op1_ldi) begin
            wr_en   = 1'b1;
            wr_data = imm_q;  // into reg 0 this jumps
          end
        end else if (is_r1) begin
          wr_en = (instr_q.r1.op == cpu8_isa_pkg::op1_not) ||
                  (instr_q.r1.op == cpu8_isa_pkg::op1_lnot);
        end
      end
      cpu8_isa_pkg::ph_mem_rd: begin
        wr_en   = done;
        wr_data = mem_rdata;
      end
      default: ;
    endcase
  end

  cpu8_regfile i_regfile (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .rd_idx_a  (ra_idx),
    .rd_idx_b  (instr_q.r2.rb),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .pc_inc    (pc_inc),
    .pc        (pc)
  );

  cpu8_alu i_alu (
    .alu_op (alu_op),
    .a_val  (rd_data_a),
    .b_val  (rd_data_b),
    .result (alu_result)
  );

  assign instr  = instr_q;
  assign halted = (phase == cpu8_isa_pkg::ph_halt);

endmodule

// ==== src/cpu8_isa_pkg.sv ====
package cpu8_isa_pkg;

  // ------------------
  // register roles
  // ------------------
  localparam logic [1:0] pc_idx     = 2'd0;  // write here means jump
  localparam logic [1:0] status_idx = 2'd3;  // compare flags land here

  // alu select is the class bit above the 3-bit op
  localparam int alu_op_bits = 4;

  // ------------------
  // 2-register ops, 1_ooo_aa_bb
  // ------------------
  localparam logic [2:0] op_mov = 3'b000;  // aa -> bb
  localparam logic [2:0] op_add = 3'b001;
  localparam logic [2:0] op_sub = 3'b010;
  localparam logic [2:0] op_shl = 3'b011;
  localparam logic [2:0] op_shr = 3'b100;
  localparam logic [2:0] op_cmp = 3'b101;  // result goes to status_idx
  localparam logic [2:0] op_and = 3'b110;
  localparam logic [2:0] op_or  = 3'b111;

  // ------------------
  // 1-register ops, 01_i_ooo_aa
  // ------------------
  localparam logic [1:0] cls_r1   = 2'b01;
  localparam logic [2:0] op1_ldi  = 3'b000;  // imm word -> aa
  localparam logic [2:0] op1_ld   = 3'b001;  // mem[imm] -> aa
  localparam logic [2:0] op1_st   = 3'b010;  // aa -> mem[imm]
  localparam logic [2:0] op1_not  = 3'b100;  // no imm word
  localparam logic [2:0] op1_lnot = 3'b101;  // no imm word

  // 0-register words, matched as a whole byte
  localparam logic [7:0] op0_halt = 8'h00;
  localparam logic [7:0] op0_nop  = 8'h01;
  localparam logic [7:0] op0_imm  = 8'h20;  // eats one imm word, no effect

  // compare flag bit positions
  localparam int st_ge = 0;
  localparam int st_gt = 1;
  localparam int st_le = 2;
  localparam int st_lt = 3;
  localparam int st_ne = 4;
  localparam int st_eq = 5;

  // ------------------
  // sequencer phases
  // ------------------
  localparam int         ph_bits   = 3;
  localparam logic [2:0] ph_fetch  = 3'd0;
  localparam logic [2:0] ph_decode = 3'd1;
  localparam logic [2:0] ph_imm    = 3'd2;  // read word after opcode
  localparam logic [2:0] ph_exec   = 3'd3;
  localparam logic [2:0] ph_mem_rd = 3'd4;
  localparam logic [2:0] ph_mem_wr = 3'd5;
  localparam logic [2:0] ph_halt   = 3'd6;

  // one instruction byte, the top bit picks which view applies
  typedef union packed {
    struct packed {
      logic       mode;  // 1 for 2-register ops
      logic [2:0] op;
      logic [1:0] ra;
      logic [1:0] rb;
    } r2;
    struct packed {
      logic [1:0] cls;   // 00 zero-register, 01 one-register
      logic       imm;   // imm word follows
      logic [2:0] op;
      logic [1:0] ra;
    } r1;
  } instr_word_t;

endpackage

// ==== src/cpu8_mem_pkg.sv ====
package cpu8_mem_pkg;

  // ------------------
  // datapath widths
  // ------------------
  localparam int word_bits = 8;  // one byte per word
  localparam int addr_bits = 8;  // 256 words of program and data

  // register file shape
  localparam int num_regs = 4;
  localparam int reg_bits = 2;   // index into the four registers

  // ------------------
  // ram timing
  // ------------------
  // idle cycles between first seeing a request and acking it,
  // so the ack lands ram_wait+1 cycles after the request shows up
  localparam int ram_wait = 2;

endpackage

// ==== src/cpu8_ram.sv ====
`timescale 1ns/1ps

module cpu8_ram (
  input  logic                               in_clk,
  input  logic                               in_rst,
  // core port
  input  logic                               mem_req,
  input  logic                               mem_write,
  input  logic [cpu8_mem_pkg::addr_bits-1:0] mem_addr,
  input  logic [cpu8_mem_pkg::word_bits-1:0] mem_wdata,
  output logic                               mem_ack,
  output logic [cpu8_mem_pkg::word_bits-1:0] mem_rdata,
  // load port, used while the core sits in reset
  input  logic                               load_en,
  input  logic [cpu8_mem_pkg::addr_bits-1:0] load_addr,
  input  logic [cpu8_mem_pkg::word_bits-1:0] load_data,
  // peek port
  input  logic [cpu8_mem_pkg::addr_bits-1:0] peek_addr,
  output logic [cpu8_mem_pkg::word_bits-1:0] peek_data
);

  logic [cpu8_mem_pkg::word_bits-1:0] mem [2**cpu8_mem_pkg::addr_bits];

  // counts cycles with req up, wide enough for ram_wait+1
  logic [$clog2(cpu8_mem_pkg::ram_wait + 2)-1:0] wait_cnt;

  // ------------------
  // wait states
  // ------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      wait_cnt <= '0;
    end else if (mem_ack || !mem_req) begin
      wait_cnt <= '0;  // ready for the next request
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // single cycle pulse, core drops req right after
  assign mem_ack = (wait_cnt == cpu8_mem_pkg::ram_wait + 1);

  // ------------------
  // array
  // ------------------
  always_ff @(posedge in_clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;  // wins over a core write
    end else if (mem_ack && mem_write) begin
      mem[mem_addr] <= mem_wdata;   // lands at the ack
    end
  end

  assign mem_rdata = mem[mem_addr];   // valid with the ack
  assign peek_data = mem[peek_addr];

endmodule

// ==== src/cpu8_regfile.sv ====
`timescale 1ns/1ps

module cpu8_regfile (
  input  logic                               in_clk,
  input  logic                               in_rst,
  // read ports, combinational
  input  logic [cpu8_mem_pkg::reg_bits-1:0]  rd_idx_a,
  input  logic [cpu8_mem_pkg::reg_bits-1:0]  rd_idx_b,
  output logic [cpu8_mem_pkg::word_bits-1:0] rd_data_a,
  output logic [cpu8_mem_pkg::word_bits-1:0] rd_data_b,
  // write port
  input  logic                               wr_en,
  input  logic [cpu8_mem_pkg::reg_bits-1:0]  wr_idx,
  input  logic [cpu8_mem_pkg::word_bits-1:0] wr_data,
  // program counter
  input  logic                               pc_inc,
  output logic [cpu8_mem_pkg::word_bits-1:0] pc
);

  logic [cpu8_mem_pkg::word_bits-1:0] regs [cpu8_mem_pkg::num_regs];

  // ------------------
  // register update
  // ------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < cpu8_mem_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;  // a write to reg 0 is a jump
    end else if (pc_inc) begin
      regs[0] <= regs[0] + 1'b1;  // reg 0 is the pc
    end
  end

  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  // pc straight out, keeps both read ports free during fetch
  assign pc = regs[0];

endmodule

// ==== src/cpu8_system.sv ====
`timescale 1ns/1ps

module cpu8_system (
  input  logic                               in_clk,
  input  logic                               in_rst,
  // ram loading
  input  logic                               load_en,
  input  logic [cpu8_mem_pkg::addr_bits-1:0] load_addr,
  input  logic [cpu8_mem_pkg::word_bits-1:0] load_data,
  // ram inspection
  input  logic [cpu8_mem_pkg::addr_bits-1:0] peek_addr,
  output logic [cpu8_mem_pkg::word_bits-1:0] peek_data,
  // core status
  output logic [cpu8_mem_pkg::word_bits-1:0] instr,
  output logic                               halted
);

  // core to ram handshake
  logic                               mem_req;
  logic                               mem_write;
  logic [cpu8_mem_pkg::addr_bits-1:0] mem_addr;
  logic [cpu8_mem_pkg::word_bits-1:0] mem_wdata;
  logic                               mem_ack;
  logic [cpu8_mem_pkg::word_bits-1:0] mem_rdata;

  cpu8_core i_core (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .instr     (instr),
    .halted    (halted)
  );

  cpu8_ram i_ram (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .peek_addr (peek_addr),
    .peek_data (peek_data)
  );

endmodule

// ==== tb.f ====
src/cpu8_mem_pkg.sv
src/cpu8_isa_pkg.sv
src/cpu8_alu.sv
src/cpu8_regfile.sv
src/cpu8_core.sv
src/cpu8_ram.sv
src/cpu8_system.sv
verif/cpu8_clk_gen.sv
verif/cpu8_sva.sv
verif/cpu8_tb.sv

// ==== verif/cpu8_clk_gen.sv ====
`timescale 1ns/1ps

module cpu8_clk_gen (
  output logic in_clk
);

  // 8 ns period, low first
  initial begin
    in_clk = 1'b0;
  end

  always #4 in_clk = ~in_clk;  // half period

endmodule

// ==== verif/cpu8_sva.sv ====
`timescale 1ns/1ps

module cpu8_sva (
  input logic                               in_clk,
  input logic                               in_rst,
  input logic                               mem_req,
  input logic                               mem_write,
  input logic [cpu8_mem_pkg::addr_bits-1:0] mem_addr,
  input logic                               mem_ack,
  input logic                               halted
);

  // --------------------
  // memory handshake
  // --------------------
  // request stays up with the same address and direction until acked
  a_req_hold: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_write))
    else $error("mem_req dropped or its address moved before mem_ack");

  a_ack_in_req: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_ack |-> mem_req)
    else $error("mem_ack seen without mem_req");

  // --------------------
  // halt
  // --------------------
  a_halt_quiet: assert property (@(posedge in_clk) disable iff (in_rst)
    halted |-> !mem_req)
    else $error("memory request issued while halted");

  a_halt_sticky: assert property (@(posedge in_clk) disable iff (in_rst)
    halted |=> halted)
    else $error("halted fell without a reset");

endmodule

bind cpu8_core cpu8_sva i_sva (
  .in_clk    (in_clk),
  .in_rst    (in_rst),
  .mem_req   (mem_req),
  .mem_write (mem_write),
  .mem_addr  (mem_addr),
  .mem_ack   (mem_ack),
  .halted    (halted)
);

// ==== verif/cpu8_tb.sv ====
`timescale 1ns/1ps

module cpu8_tb;

  logic                               in_clk;
  logic                               in_rst;
  logic                               load_en;
  logic [cpu8_mem_pkg::addr_bits-1:0] load_addr;
  logic [cpu8_mem_pkg::word_bits-1:0] load_data;
  logic [cpu8_mem_pkg::addr_bits-1:0] peek_addr;
  logic [cpu8_mem_pkg::word_bits-1:0] peek_data;
  logic [cpu8_mem_pkg::word_bits-1:0] instr;
  logic                               halted;

  logic [7:0] image [256];  // whole ram contents for the next run
  int         prog_len;     // next free program address

  cpu8_clk_gen i_clk_gen (.in_clk(in_clk));

  cpu8_system i_dut (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .peek_addr (peek_addr),
    .peek_data (peek_data),
    .instr     (instr),
    .halted    (halted)
  );

  // --------------------
  // program building
  // --------------------
  task automatic clear_image();
    for (int a = 0; a < 256; a++) begin
      image[a] = 8'(a) ^ 8'hc3;  // every address bit shows in the word
    end
    prog_len = 0;
  endtask

  task automatic push_word(input logic [7:0] w);
    image[prog_len] = w;
    prog_len++;
  endtask

  task automatic two_reg_op(input logic [2:0] op, input logic [1:0] ra, input logic [1:0] rb);
    push_word({1'b1, op, ra, rb});
  endtask

  task automatic unary_op(input logic [2:0] op, input logic [1:0] ra);
    push_word({cpu8_isa_pkg::cls_r1, 1'b0, op, ra});
  endtask

  // opcode plus its immediate word
  task automatic imm_op(input logic [2:0] op, input logic [1:0] ra, input logic [7:0] w);
    push_word({cpu8_isa_pkg::cls_r1, 1'b1, op, ra});
    push_word(w);
  endtask

  task automatic load_imm(input logic [1:0] ra, input logic [7:0] val);
    imm_op(cpu8_isa_pkg::op1_ldi, ra, val);
  endtask

  // r1 = val, r1 = r1 op r2, mem[addr] = r1
  task automatic apply_and_store(input logic [2:0] op, input logic [7:0] val,
                                 input logic [7:0] addr);
    load_imm(2'd1, val);
    two_reg_op(op, 2'd1, 2'd2);
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, addr);
  endtask

  // flags land in r3, stored from there
  task automatic compare_and_store(input logic [7:0] a, input logic [7:0] b,
                                   input logic [7:0] addr);
    load_imm(2'd1, a);
    load_imm(2'd2, b);
    two_reg_op(cpu8_isa_pkg::op_cmp, 2'd1, 2'd2);
    imm_op(cpu8_isa_pkg::op1_st, 2'd3, addr);
  endtask

  // --------------------
  // run and check
  // --------------------
  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic run_program();
    int cycles;
    @(posedge in_clk);
    in_rst <= 1'b1;
    repeat (8) @(posedge in_clk);
    for (int a = 0; a < 256; a++) begin  // core still in reset
      load_en   <= 1'b1;
      load_addr <= 8'(a);
      load_data <= image[a];
      @(posedge in_clk);
    end
    load_en <= 1'b0;
    in_rst  <= 1'b0;
    cycles = 0;
    while (!halted && cycles < 4000) begin
      @(negedge in_clk);
      cycles++;
    end
    assert (halted) else begin
      $display("program did not reach halt within %0d cycles", cycles);
      abort_run();
    end
  endtask

  task automatic check_word(input logic [7:0] addr, input logic [7:0] exp);
    @(posedge in_clk);
    peek_addr <= addr;
    @(negedge in_clk);  // peek settled
    assert (peek_data === exp) else begin
      $display("** Error at %0t: peek_data at %02h is %02h, expected %02h",
               $time, addr, peek_data, exp);
      abort_run();
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_arith();
    logic [7:0] a;
    logic [7:0] b;
    a = 8'($urandom);
    b = 8'($urandom);
    clear_image();
    load_imm(2'd2, b);  // second operand stays in r2
    apply_and_store(cpu8_isa_pkg::op_add, a, 8'h80);
    apply_and_store(cpu8_isa_pkg::op_sub, a, 8'h81);
    apply_and_store(cpu8_isa_pkg::op_and, a, 8'h82);
    apply_and_store(cpu8_isa_pkg::op_or, a, 8'h83);
    push_word(cpu8_isa_pkg::op0_halt);
    run_program();
    check_word(8'h80, 8'(a + b));  // wraps at 8 bits
    check_word(8'h81, 8'(a - b));
    check_word(8'h82, a & b);
    check_word(8'h83, a | b);
  endtask

  task automatic test_shift_not();
    logic [7:0] v;
    logic [7:0] s_small;
    logic [7:0] s_big;
    v       = 8'($urandom);
    s_small = 8'($urandom_range(7, 1));
    s_big   = 8'($urandom_range(255, 8));
    clear_image();
    load_imm(2'd2, s_small);
    apply_and_store(cpu8_isa_pkg::op_shl, v, 8'h80);
    apply_and_store(cpu8_isa_pkg::op_shr, v, 8'h81);
    load_imm(2'd2, s_big);  // whole word shifted out
    apply_and_store(cpu8_isa_pkg::op_shl, v, 8'h82);
    apply_and_store(cpu8_isa_pkg::op_shr, v, 8'h83);
    load_imm(2'd1, v);
    unary_op(cpu8_isa_pkg::op1_not, 2'd1);
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, 8'h84);
    load_imm(2'd1, 8'h00);
    unary_op(cpu8_isa_pkg::op1_lnot, 2'd1);
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, 8'h85);
    load_imm(2'd1, v | 8'h01);  // surely nonzero
    unary_op(cpu8_isa_pkg::op1_lnot, 2'd1);
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, 8'h86);
    push_word(cpu8_isa_pkg::op0_halt);
    run_program();
    check_word(8'h80, 8'(v << s_small));
    check_word(8'h81, v >> s_small);
    check_word(8'h82, 8'h00);
    check_word(8'h83, 8'h00);
    check_word(8'h84, ~v);
    check_word(8'h85, 8'h01);
    check_word(8'h86, 8'h00);
  endtask

  task automatic test_compare();
    logic [7:0] x;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [7:0] eq_flags;
    logic [7:0] lt_flags;
    logic [7:0] gt_flags;
    x  = 8'($urandom);
    lo = 8'($urandom_range(254, 0));
    hi = 8'($urandom_range(255, lo + 1));
    // expected flag bytes from the bit positions
    eq_flags = 8'((1 << cpu8_isa_pkg::st_eq) | (1 << cpu8_isa_pkg::st_le) |
                  (1 << cpu8_isa_pkg::st_ge));
    lt_flags = 8'((1 << cpu8_isa_pkg::st_ne) | (1 << cpu8_isa_pkg::st_lt) |
                  (1 << cpu8_isa_pkg::st_le));
    gt_flags = 8'((1 << cpu8_isa_pkg::st_ne) | (1 << cpu8_isa_pkg::st_gt) |
                  (1 << cpu8_isa_pkg::st_ge));
    clear_image();
    compare_and_store(x, x, 8'h80);
    compare_and_store(lo, hi, 8'h81);
    compare_and_store(hi, lo, 8'h82);
    push_word(cpu8_isa_pkg::op0_halt);
    run_program();
    check_word(8'h80, eq_flags);
    check_word(8'h81, lt_flags);
    check_word(8'h82, gt_flags);
  endtask

  task automatic test_move_nop();
    logic [7:0] d;
    logic [7:0] k3;
    int         pc_store_at;
    d  = 8'($urandom);
    k3 = d ^ 8'h3c;
    clear_image();
    image[8'h90] = d;
    load_imm(2'd3, k3);
    imm_op(cpu8_isa_pkg::op1_ld, 2'd1, 8'h90);
    two_reg_op(cpu8_isa_pkg::op_mov, 2'd1, 2'd2);  // r1 -> r2
    push_word(cpu8_isa_pkg::op0_nop);
    push_word(cpu8_isa_pkg::op0_imm);
    push_word(cpu8_isa_pkg::op0_halt);  // eaten as the immediate
    pc_store_at = prog_len;
    imm_op(cpu8_isa_pkg::op1_st, 2'd0, 8'h94);  // pc after its own imm word
    imm_op(cpu8_isa_pkg::op1_st, 2'd2, 8'h91);
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, 8'h92);
    imm_op(cpu8_isa_pkg::op1_st, 2'd3, 8'h93);
    push_word(cpu8_isa_pkg::op0_halt);
    run_program();
    check_word(8'h90, d);
    check_word(8'h91, d);
    check_word(8'h92, d);
    check_word(8'h93, k3);
    check_word(8'h94, 8'(pc_store_at + 2));
  endtask

  task automatic test_jump();
    logic [7:0] marker;
    marker = 8'($urandom);
    clear_image();
    image[8'ha0] = marker;
    load_imm(2'd1, ~marker);
    load_imm(2'd0, 8'(prog_len + 4));  // lands just past the next store
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, 8'ha0);
    imm_op(cpu8_isa_pkg::op1_st, 2'd1, 8'ha1);
    push_word(cpu8_isa_pkg::op0_halt);
    run_program();
    assert (instr === cpu8_isa_pkg::op0_halt) else begin
      $display("** Error at %0t: instr is %02h, expected %02h",
               $time, instr, cpu8_isa_pkg::op0_halt);
      abort_run();
    end
    check_word(8'ha0, marker);
    check_word(8'ha1, ~marker);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    in_rst    = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    peek_addr = '0;
    void'($urandom(32'h817d));
    test_arith();
    test_shift_not();
    test_compare();
    test_move_nop();
    test_jump();
    $display("No errors");
    $finish;
  end

endmodule
